// ==== cluster_bus.f ====
+incdir+verilog
verilog/apb_pkg.sv
verilog/bus_map_pkg.sv
verilog/bus_addr_decoder.sv
verilog/bus_target_arbiter.sv
verilog/bus_response_mux.sv
verilog/cluster_bus.sv
tb/tb_clock_gen.sv
tb/tb_cluster_bus.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal -f cluster_bus.f \
  --top-module tb_cluster_bus -o tb_cluster_bus_sim > build.log 2>&1 \
  && ./obj_dir/tb_cluster_bus_sim > "$LOG" 2>&1 \
  || echo "Build or simulation returned an error, see build.log and $LOG"

grep -qx "Result: PASSED" "$LOG" \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int PERIOD_NS    = 20;
  localparam int RESET_CYCLES = 3;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset is released just after a rising edge, like every other input
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

// ==== tb/tb_cluster_bus.sv ====
`timescale 1ns/1ps
`include "cluster_bus_settings.svh"

module tb_cluster_bus;

  localparam int NI            = `NB_INITIATORS;
  localparam int NT            = `NB_TARGETS;
  localparam int CLK_PERIOD_NS = 20;
  localparam int TCDM          = bus_map_pkg::TGT_TCDM;
  localparam int PERIPH        = bus_map_pkg::TGT_PERIPH;
  localparam int EXT           = bus_map_pkg::TGT_EXT;
  localparam int NONE          = -1;

  // Entries with the same group number start together, and the entries of
  // one initiator within a group run back to back
  typedef struct {
    int          grp;
    int          init;
    int          cid;
    logic [31:0] addr;
    logic        wr;
    logic [31:0] wdata;
    int          tgt;
    logic [31:0] rdata;
    logic        err;
  } entry_t;

  typedef struct {
    int          tgt;
    logic [31:0] addr;
    logic        wr;
    logic [31:0] wdata;
  } access_t;

  logic                     clk;
  logic                     rst_n;
  bus_map_pkg::cluster_id_t cluster_id;
  logic                     init_psel    [NI];
  logic                     init_penable [NI];
  apb_pkg::addr_t           init_paddr   [NI];
  logic                     init_pwrite  [NI];
  apb_pkg::data_t           init_pwdata  [NI];
  logic                     init_pready  [NI];
  apb_pkg::data_t           init_prdata  [NI];
  logic                     init_pslverr [NI];
  logic                     tgt_psel     [NT];
  logic                     tgt_penable  [NT];
  apb_pkg::addr_t           tgt_paddr    [NT];
  logic                     tgt_pwrite   [NT];
  apb_pkg::data_t           tgt_pwdata   [NT];
  logic                     tgt_pready   [NT];
  apb_pkg::data_t           tgt_prdata   [NT];
  logic                     tgt_pslverr  [NT];

  entry_t      table_q  [$];
  access_t     access_q [$];
  logic [31:0] mem [NT][16];
  int          wait_left [NT];
  logic [31:0] lcg_state = 32'h0f35_c0be;
  bit          table_built;

  tb_clock_gen u_clock_gen (.clk_o(clk), .rst_n_o(rst_n));

  cluster_bus UUT (
    .clk_i(clk), .rst_n_i(rst_n), .cluster_id_i(cluster_id),
    .init_psel_i(init_psel), .init_penable_i(init_penable), .init_paddr_i(init_paddr),
    .init_pwrite_i(init_pwrite), .init_pwdata_i(init_pwdata), .init_pready_o(init_pready),
    .init_prdata_o(init_prdata), .init_pslverr_o(init_pslverr),
    .tgt_psel_o(tgt_psel), .tgt_penable_o(tgt_penable), .tgt_paddr_o(tgt_paddr),
    .tgt_pwrite_o(tgt_pwrite), .tgt_pwdata_o(tgt_pwdata), .tgt_pready_i(tgt_pready),
    .tgt_prdata_i(tgt_prdata), .tgt_pslverr_i(tgt_pslverr)
  );

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected));
    end
  endtask

  task automatic add_entry(int grp, int init, int cid, logic [31:0] addr, logic wr,
                           logic [31:0] wdata, int tgt, logic [31:0] rdata, logic err);
    entry_t e;
    e = '{grp, init, cid, addr, wr, wdata, tgt, rdata, err};
    table_q.push_back(e);
  endtask

  // Each target logs its setup cycles and answers after 0 to 3 wait states
  always @(posedge clk) begin : target_models
    access_t     rec;
    logic [31:0] rnd;
    #1;
    for (int t = 0; t < NT; t++) begin
      tgt_pready[t]  = 1'b0;
      tgt_prdata[t]  = '0;
      tgt_pslverr[t] = 1'b0;
      if (tgt_psel[t] && !tgt_penable[t]) begin
        rnd          = next_random();
        wait_left[t] = int'(rnd[31:30]);
        rec.tgt      = t;
        rec.addr     = tgt_paddr[t];
        rec.wr       = tgt_pwrite[t];
        rec.wdata    = tgt_pwdata[t];
        access_q.push_back(rec);
      end else if (tgt_psel[t] && tgt_penable[t]) begin
        if (wait_left[t] > 0) begin
          wait_left[t]--;
        end else begin
          tgt_pready[t] = 1'b1;
          if (tgt_pwrite[t]) begin
            mem[t][tgt_paddr[t][5:2]] = tgt_pwdata[t];
          end else begin
            tgt_prdata[t] = mem[t][tgt_paddr[t][5:2]];
          end
        end
      end
    end
  end

  task automatic run_entry(int n);
    int          i;
    logic [31:0] rdata;
    logic        err;
    i = table_q[n].init;
    @(posedge clk);
    #1;
    init_psel[i]    = 1'b1;
    init_paddr[i]   = table_q[n].addr;
    init_pwrite[i]  = table_q[n].wr;
    init_pwdata[i]  = table_q[n].wdata;
    @(posedge clk);
    #1;
    init_penable[i] = 1'b1;
    @(negedge clk);
    while (!init_pready[i]) begin
      @(negedge clk);
    end
    rdata = init_prdata[i];
    err   = init_pslverr[i];
    @(posedge clk);
    #1;
    init_psel[i]    = 1'b0;
    init_penable[i] = 1'b0;
    check_value($sformatf("init_prdata_o[%0d]", i), rdata, table_q[n].rdata);
    check_value($sformatf("init_pslverr_o[%0d]", i), 32'(err), 32'(table_q[n].err));
  endtask

  task automatic run_initiator(int init, int first, int last);
    for (int e = first; e <= last; e++) begin
      if (table_q[e].init == init) begin
        run_entry(e);
      end
    end
  endtask

  // Every mapped entry must show up exactly once, at its own target and unchanged
  task automatic check_routing(int first, int last);
    int mapped;
    bit found;
    mapped = 0;
    for (int e = first; e <= last; e++) begin
      if (table_q[e].tgt != NONE) begin
        mapped++;
      end
    end
    check_value("target setup count", access_q.size(), mapped);
    for (int e = first; e <= last; e++) begin
      found = 1'b0;
      foreach (access_q[k]) begin
        if (table_q[e].tgt != NONE && access_q[k].addr == table_q[e].addr) begin
          found = 1'b1;
          check_value("target index", access_q[k].tgt, table_q[e].tgt);
          check_value("tgt_pwrite_o", 32'(access_q[k].wr), 32'(table_q[e].wr));
          check_value("tgt_pwdata_o", access_q[k].wdata, table_q[e].wdata);
        end
      end
      if (table_q[e].tgt != NONE && !found) begin
        abort_run($sformatf("No target received the access to address %h", table_q[e].addr));
      end
    end
  endtask

  // Entries of one group share a target, so its first users must all be
  // different initiators or one of them was served twice while another waited
  task automatic verify_grant_order(int first, int last);
    bit seen [NI];
    int users;
    int owner;
    users = 0;
    for (int j = 0; j < NI; j++) begin
      seen[j] = 1'b0;
    end
    for (int e = first; e <= last; e++) begin
      if (table_q[e].tgt != NONE && !seen[table_q[e].init]) begin
        seen[table_q[e].init] = 1'b1;
        users++;
      end
    end
    for (int j = 0; j < NI; j++) begin
      seen[j] = 1'b0;
    end
    for (int k = 0; k < users; k++) begin
      owner = NONE;
      for (int e = first; e <= last; e++) begin
        if (table_q[e].addr == access_q[k].addr) begin
          owner = table_q[e].init;
        end
      end
      if (owner == NONE || seen[owner]) begin
        abort_run($sformatf("Access to address %h was served out of round-robin order",
                            access_q[k].addr));
      end
      seen[owner] = 1'b1;
    end
  endtask

  initial begin : watchdog
    wait (table_built);
    #(table_q.size() * 20 * CLK_PERIOD_NS);
    abort_run("Timeout: the transfers did not complete in the expected time");
  end

  initial begin : stimulus
    int first;
    int last;
    cluster_id = '0;
    for (int i = 0; i < NI; i++) begin
      init_psel[i]    = 1'b0;
      init_penable[i] = 1'b0;
      init_paddr[i]   = '0;
      init_pwrite[i]  = 1'b0;
      init_pwdata[i]  = '0;
    end
    for (int t = 0; t < NT; t++) begin
      tgt_pready[t]  = 1'b0;
      tgt_prdata[t]  = '0;
      tgt_pslverr[t] = 1'b0;
      wait_left[t]   = 0;
      for (int w = 0; w < 16; w++) begin
        mem[t][w] = 32'hc0de_0000 | (t << 8) | w;
      end
    end

    // grp init cid addr wr wdata target rdata err
    add_entry(0, 0, 0, 32'h1000_0004, 1, 32'h1111_0001, TCDM, 32'h0, 0);
    add_entry(1, 1, 0, 32'h1000_0004, 0, 32'h0, TCDM, 32'h1111_0001, 0);
    add_entry(2, 2, 0, 32'h1020_0008, 1, 32'h2222_0002, PERIPH, 32'h0, 0);
    add_entry(3, 3, 0, 32'h1020_0008, 0, 32'h0, PERIPH, 32'h2222_0002, 0);
    add_entry(4, 1, 0, 32'h0000_0010, 1, 32'h3333_0003, EXT, 32'h0, 0);
    add_entry(5, 2, 0, 32'h8000_0014, 1, 32'h4444_0004, EXT, 32'h0, 0);
    add_entry(6, 0, 0, 32'h0000_0010, 0, 32'h0, EXT, 32'h3333_0003, 0);
    // Same address, cluster 0 sees it above periph and cluster 1 inside tcdm
    add_entry(7, 1, 0, 32'h1040_0018, 1, 32'h5555_0005, EXT, 32'h0, 0);
    add_entry(8, 1, 1, 32'h1040_0018, 1, 32'h6666_0006, TCDM, 32'h0, 0);
    add_entry(9, 3, 1, 32'h1040_0018, 0, 32'h0, TCDM, 32'h6666_0006, 0);
    add_entry(10, 2, 0, 32'h1040_0018, 0, 32'h0, EXT, 32'h5555_0005, 0);
    add_entry(11, 2, 0, 32'h1010_0000, 0, 32'h0, NONE, 32'h0, 1);
    add_entry(12, 0, 1, 32'h1050_0020, 1, 32'hdead_beef, NONE, 32'h0, 1);
    // Initiator 0 asks again while the others still wait for their turn
    add_entry(13, 0, 0, 32'h1000_0020, 1, 32'h7777_0000, TCDM, 32'h0, 0);
    add_entry(13, 1, 0, 32'h1000_0024, 1, 32'h7777_0001, TCDM, 32'h0, 0);
    add_entry(13, 2, 0, 32'h1000_0028, 1, 32'h7777_0002, TCDM, 32'h0, 0);
    add_entry(13, 3, 0, 32'h1000_002C, 1, 32'h7777_0003, TCDM, 32'h0, 0);
    add_entry(13, 0, 0, 32'h1000_0030, 1, 32'h7777_0004, TCDM, 32'h0, 0);
    add_entry(14, 3, 0, 32'h1000_0020, 0, 32'h0, TCDM, 32'h7777_0000, 0);
    add_entry(15, 0, 0, 32'h1000_002C, 0, 32'h0, TCDM, 32'h7777_0003, 0);
    table_built = 1'b1;

    wait (rst_n);
    first = 0;
    while (first < table_q.size()) begin
      last = first;
      while (last + 1 < table_q.size() && table_q[last + 1].grp == table_q[first].grp) begin
        last++;
      end
      access_q.delete();
      @(posedge clk);
      #1;
      cluster_id = bus_map_pkg::cluster_id_t'(table_q[first].cid);
      fork
        run_initiator(0, first, last);
        run_initiator(1, first, last);
        run_initiator(2, first, last);
        run_initiator(3, first, last);
      join
      check_routing(first, last);
      verify_grant_order(first, last);
      first = last + 1;
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== verilog/apb_pkg.sv ====
`include "cluster_bus_settings.svh"

package apb_pkg;

  // Byte address carried in paddr
  typedef logic [`ADDR_WIDTH-1:0] addr_t;

  // Word carried in pwdata and prdata
  typedef logic [`DATA_WIDTH-1:0] data_t;

endpackage

// ==== verilog/bus_addr_decoder.sv ====
`timescale 1ns/1ps
`include "cluster_bus_settings.svh"

module bus_addr_decoder (
  input  logic                     psel_i,
  input  apb_pkg::addr_t           paddr_i,
  input  bus_map_pkg::cluster_id_t cluster_id_i,
  output bus_map_pkg::target_sel_t req_o,
  output logic                     decode_err_o
);

  apb_pkg::addr_t offset;
  apb_pkg::addr_t tcdm_start;
  apb_pkg::addr_t tcdm_end;
  apb_pkg::addr_t periph_start;
  apb_pkg::addr_t periph_end;
  logic           hit_tcdm;
  logic           hit_periph;
  logic           hit_ext;

  // Both cluster windows move together with the cluster id
  assign offset       = apb_pkg::addr_t'(cluster_id_i) << `CLUSTER_OFFSET_SHIFT;
  assign tcdm_start   = `TCDM_START_ADDR + offset;
  assign tcdm_end     = `TCDM_END_ADDR + offset;
  assign periph_start = `PERIPH_START_ADDR + offset;
  assign periph_end   = `PERIPH_END_ADDR + offset;

  assign hit_tcdm   = (paddr_i >= tcdm_start) && (paddr_i <= tcdm_end);
  assign hit_periph = (paddr_i >= periph_start) && (paddr_i <= periph_end);

  // Ext owns both ends of the address space around the cluster
  assign hit_ext = (paddr_i < tcdm_start) || (paddr_i > periph_end);

  always_comb begin
    req_o = '0;
    req_o[bus_map_pkg::TGT_TCDM]   = psel_i && hit_tcdm;
    req_o[bus_map_pkg::TGT_PERIPH] = psel_i && hit_periph;
    req_o[bus_map_pkg::TGT_EXT]    = psel_i && hit_ext;
  end

  // What is left between the two windows is unmapped
  assign decode_err_o = psel_i && !hit_tcdm && !hit_periph && !hit_ext;

  // A selected access lands in exactly one place, either a target or the gap
  always_comb begin
    if (psel_i) begin
      assert ($onehot({req_o, decode_err_o}))
        else $error("decoder: address %h maps to %b err %b", paddr_i, req_o, decode_err_o);
    end
  end

endmodule

// ==== verilog/bus_map_pkg.sv ====
`include "cluster_bus_settings.svh"

package bus_map_pkg;

  // Target port indices
  typedef enum logic [1:0] {
    TGT_TCDM   = 2'd0,
    TGT_PERIPH = 2'd1,
    TGT_EXT    = 2'd2
  } target_e;

  // One bit per target, at most one set per initiator
  typedef logic [`NB_TARGETS-1:0] target_sel_t;

  // One bit per initiator, at most one set per target
  typedef logic [`NB_INITIATORS-1:0] initiator_sel_t;

  typedef logic [`CLUSTER_ID_WIDTH-1:0] cluster_id_t;

endpackage

// ==== verilog/bus_response_mux.sv ====
`timescale 1ns/1ps
`include "cluster_bus_settings.svh"

module bus_response_mux (
  input  logic           grant_i       [`NB_TARGETS],
  input  logic           access_i      [`NB_TARGETS],
  input  logic           decode_err_i,
  input  logic           init_penable_i,
  input  logic           tgt_pready_i  [`NB_TARGETS],
  input  apb_pkg::data_t tgt_prdata_i  [`NB_TARGETS],
  input  logic           tgt_pslverr_i [`NB_TARGETS],
  output logic           pready_o,
  output apb_pkg::data_t prdata_o,
  output logic           pslverr_o
);

  bus_map_pkg::target_sel_t granted;

  always_comb begin
    for (int t = 0; t < `NB_TARGETS; t++) begin
      granted[t] = grant_i[t];
    end
  end

  always_comb begin
    pready_o  = 1'b0;
    prdata_o  = '0;
    pslverr_o = 1'b0;
    if (decode_err_i && init_penable_i) begin
      // Unmapped address is answered at once with an error
      pready_o  = 1'b1;
      pslverr_o = 1'b1;
    end else begin
      for (int t = 0; t < `NB_TARGETS; t++) begin
        if (granted[t] && access_i[t]) begin
          pready_o  = tgt_pready_i[t];
          prdata_o  = tgt_prdata_i[t];
          pslverr_o = tgt_pslverr_i[t];
        end
      end
    end
  end

  // Two arbiters may never own the same initiator at once
  always_comb begin
    assert ($onehot0(granted))
      else $error("response mux: initiator granted by targets %b", granted);
  end

endmodule

// ==== verilog/bus_target_arbiter.sv ====
`timescale 1ns/1ps
`include "cluster_bus_settings.svh"

module bus_target_arbiter (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        req_i         [`NB_INITIATORS],
  input  apb_pkg::addr_t              init_paddr_i  [`NB_INITIATORS],
  input  logic                        init_pwrite_i [`NB_INITIATORS],
  input  apb_pkg::data_t              init_pwdata_i [`NB_INITIATORS],
  input  logic                        tgt_pready_i,
  output bus_map_pkg::initiator_sel_t grant_o,
  output logic                        access_o,
  output logic                        tgt_psel_o,
  output logic                        tgt_penable_o,
  output apb_pkg::addr_t              tgt_paddr_o,
  output logic                        tgt_pwrite_o,
  output apb_pkg::data_t              tgt_pwdata_o
);

  localparam int IDX_W = $clog2(`NB_INITIATORS);

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_SETUP,
    ARB_ACCESS
  } arb_state_e;

  arb_state_e       state_q;
  logic [IDX_W-1:0] winner_q;
  logic [IDX_W-1:0] next_idx;
  logic             found;

  // winner_q is the current owner during a transfer and the round-robin
  // pointer while idle, so the search always starts after the last winner
  always_comb begin
    int cand;
    next_idx = winner_q;
    found    = 1'b0;
    for (int k = 1; k <= `NB_INITIATORS; k++) begin
      cand = (int'(winner_q) + k) % `NB_INITIATORS;
      if (!found && req_i[cand]) begin
        found    = 1'b1;
        next_idx = IDX_W'(cand);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= ARB_IDLE;
      winner_q <= IDX_W'(`NB_INITIATORS - 1);
    end else begin
      case (state_q)
        ARB_IDLE: begin
          if (found) begin
            state_q  <= ARB_SETUP;
            winner_q <= next_idx;
          end
        end
        ARB_SETUP: state_q <= ARB_ACCESS;
        ARB_ACCESS: begin
          if (tgt_pready_i) begin
            state_q <= ARB_IDLE;
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  assign grant_o = (state_q != ARB_IDLE) ?
                   bus_map_pkg::initiator_sel_t'(1'b1) << winner_q : '0;

  assign access_o      = (state_q == ARB_ACCESS);
  assign tgt_psel_o    = (state_q != ARB_IDLE);
  assign tgt_penable_o = (state_q == ARB_ACCESS);

  // The owning initiator holds its fields until it sees pready
  assign tgt_paddr_o  = init_paddr_i[winner_q];
  assign tgt_pwrite_o = init_pwrite_i[winner_q];
  assign tgt_pwdata_o = init_pwdata_i[winner_q];

  // Relies on the initiator keeping its request stable while it waits
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tgt_psel_o && !(tgt_penable_o && tgt_pready_i)
    |=> $stable(tgt_paddr_o) && $stable(tgt_pwrite_o));

  // The owner keeps selecting this target until its transfer completes
  a_owner_requests: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tgt_psel_o |-> req_i[winner_q]);

endmodule

// ==== verilog/cluster_bus.sv ====
`timescale 1ns/1ps
`include "cluster_bus_settings.svh"

module cluster_bus (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  bus_map_pkg::cluster_id_t cluster_id_i,

  // Initiators: instr, data, dma, ext
  input  logic                     init_psel_i    [`NB_INITIATORS],
  input  logic                     init_penable_i [`NB_INITIATORS],
  input  apb_pkg::addr_t           init_paddr_i   [`NB_INITIATORS],
  input  logic                     init_pwrite_i  [`NB_INITIATORS],
  input  apb_pkg::data_t           init_pwdata_i  [`NB_INITIATORS],
  output logic                     init_pready_o  [`NB_INITIATORS],
  output apb_pkg::data_t           init_prdata_o  [`NB_INITIATORS],
  output logic                     init_pslverr_o [`NB_INITIATORS],

  // Targets: tcdm, periph, ext
  output logic                     tgt_psel_o     [`NB_TARGETS],
  output logic                     tgt_penable_o  [`NB_TARGETS],
  output apb_pkg::addr_t           tgt_paddr_o    [`NB_TARGETS],
  output logic                     tgt_pwrite_o   [`NB_TARGETS],
  output apb_pkg::data_t           tgt_pwdata_o   [`NB_TARGETS],
  input  logic                     tgt_pready_i   [`NB_TARGETS],
  input  apb_pkg::data_t           tgt_prdata_i   [`NB_TARGETS],
  input  logic                     tgt_pslverr_i  [`NB_TARGETS]
);

  bus_map_pkg::target_sel_t    init_req   [`NB_INITIATORS];
  logic                        decode_err [`NB_INITIATORS];
  bus_map_pkg::initiator_sel_t tgt_grant  [`NB_TARGETS];
  logic                        tgt_access [`NB_TARGETS];

  // Same request and grant bits, regrouped per target and per initiator
  logic                        arb_req    [`NB_TARGETS][`NB_INITIATORS];
  logic                        mux_grant  [`NB_INITIATORS][`NB_TARGETS];

  for (genvar i = 0; i < `NB_INITIATORS; i++) begin : g_transpose_i
    for (genvar t = 0; t < `NB_TARGETS; t++) begin : g_transpose_t
      assign arb_req[t][i]   = init_req[i][t];
      assign mux_grant[i][t] = tgt_grant[t][i];
    end
  end

  for (genvar i = 0; i < `NB_INITIATORS; i++) begin : g_decoder
    bus_addr_decoder u_decoder (
      .psel_i       (init_psel_i[i]),
      .paddr_i      (init_paddr_i[i]),
      .cluster_id_i (cluster_id_i),
      .req_o        (init_req[i]),
      .decode_err_o (decode_err[i])
    );
  end

  for (genvar t = 0; t < `NB_TARGETS; t++) begin : g_arbiter
    bus_target_arbiter u_arbiter (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .req_i         (arb_req[t]),
      .init_paddr_i  (init_paddr_i),
      .init_pwrite_i (init_pwrite_i),
      .init_pwdata_i (init_pwdata_i),
      .tgt_pready_i  (tgt_pready_i[t]),
      .grant_o       (tgt_grant[t]),
      .access_o      (tgt_access[t]),
      .tgt_psel_o    (tgt_psel_o[t]),
      .tgt_penable_o (tgt_penable_o[t]),
      .tgt_paddr_o   (tgt_paddr_o[t]),
      .tgt_pwrite_o  (tgt_pwrite_o[t]),
      .tgt_pwdata_o  (tgt_pwdata_o[t])
    );
  end

  for (genvar i = 0; i < `NB_INITIATORS; i++) begin : g_response
    bus_response_mux u_response (
      .grant_i        (mux_grant[i]),
      .access_i       (tgt_access),
      .decode_err_i   (decode_err[i]),
      .init_penable_i (init_penable_i[i]),
      .tgt_pready_i   (tgt_pready_i),
      .tgt_prdata_i   (tgt_prdata_i),
      .tgt_pslverr_i  (tgt_pslverr_i),
      .pready_o       (init_pready_o[i]),
      .prdata_o       (init_prdata_o[i]),
      .pslverr_o      (init_pslverr_o[i])
    );
  end

endmodule

// ==== verilog/cluster_bus_settings.svh ====
`ifndef CLUSTER_BUS_SETTINGS_SVH
`define CLUSTER_BUS_SETTINGS_SVH

// Initiator ports in index order: instr, data, dma, ext
`define NB_INITIATORS 4

// Target ports in index order: tcdm, periph, ext
`define NB_TARGETS 3

// APB field widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 32

// Cluster id and the shift that turns it into a window offset
`define CLUSTER_ID_WIDTH     6
`define CLUSTER_OFFSET_SHIFT 22

// Windows of cluster 0, other clusters are shifted by their offset
`define TCDM_START_ADDR   32'h1000_0000
`define TCDM_END_ADDR     32'h100F_FFFF

// The gap between TCDM_END_ADDR and PERIPH_START_ADDR has no target
`define PERIPH_START_ADDR 32'h1020_0000
`define PERIPH_END_ADDR   32'h103F_FFFF

// Everything below the tcdm window and above the periph window
// belongs to the ext target

`endif
